/* CoreSC.f */
hdl/CorePkg.sv
hdl/InstDecoder.sv
hdl/DatapathController.sv
hdl/GPRegisters.sv
hdl/ALU.sv
hdl/CoreSC.sv
tests/CoreSC_checker.sv
tests/CoreSCTb.sv

/* hdl/ALU.sv */
//--------------------------------------------------------------------
// ALU
// Combinational arithmetic, logic, shift and compare unit of the
// core. PASSB forwards operand B for LUI.
//--------------------------------------------------------------------

`timescale 1ns/1ps

module ALU (
    input  CorePkg::AluOp i_op,      // Operation
    input  CorePkg::Data  i_dataA,   // Operand A
    input  CorePkg::Data  i_dataB,   // Operand B
    output CorePkg::Data  o_result); // Result

    logic [4:0] shamt;  // Shift amount

    assign shamt = i_dataB[4:0];

    always_comb begin
        case (i_op)
            CorePkg::AluAdd:   o_result = i_dataA + i_dataB;
            CorePkg::AluSub:   o_result = i_dataA - i_dataB;
            CorePkg::AluSll:   o_result = i_dataA << shamt;
            CorePkg::AluSlt:   o_result = {31'b0, $signed(i_dataA) < $signed(i_dataB)};
            CorePkg::AluSltu:  o_result = {31'b0, i_dataA < i_dataB};
            CorePkg::AluXor:   o_result = i_dataA ^ i_dataB;
            CorePkg::AluSrl:   o_result = i_dataA >> shamt;
            // Arithmetic shift keeps the sign bit
            CorePkg::AluSra:   o_result = CorePkg::Data'($signed(i_dataA) >>> shamt);
            CorePkg::AluOr:    o_result = i_dataA | i_dataB;
            CorePkg::AluAnd:   o_result = i_dataA & i_dataB;
            CorePkg::AluPassB: o_result = i_dataB;  // LUI
            default:           o_result = '0;
        endcase
    end

endmodule

/* hdl/CorePkg.sv */
//--------------------------------------------------------------------
// CorePkg
// Shared types for the single-cycle RV32I core: data and address
// types, opcode and ALU operation enums, datapath selector codes,
// the packed control word and the data bus request.
//--------------------------------------------------------------------

package CorePkg;

    typedef logic [31:0] Data;      // Register or memory value
    typedef logic [31:0] InstAddr;  // Instruction byte address
    typedef logic [31:0] DataAddr;  // Data byte address
    typedef logic [31:0] Inst;      // Instruction word
    typedef logic [4:0]  GPRAddr;   // Register index

    localparam InstAddr ResetPc = 32'h0000_0000;  // PC after reset

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OpcLui    = 7'b0110111,
        OpcAuipc  = 7'b0010111,
        OpcJal    = 7'b1101111,
        OpcJalr   = 7'b1100111,
        OpcBranch = 7'b1100011,
        OpcLoad   = 7'b0000011,
        OpcStore  = 7'b0100011,
        OpcOpImm  = 7'b0010011,
        OpcOp     = 7'b0110011
    } Opcode;

    // funct3 codes for ALU operations
    localparam logic [2:0] F3Add  = 3'b000;  // ADD and SUB
    localparam logic [2:0] F3Sll  = 3'b001;
    localparam logic [2:0] F3Slt  = 3'b010;
    localparam logic [2:0] F3Sltu = 3'b011;
    localparam logic [2:0] F3Xor  = 3'b100;
    localparam logic [2:0] F3Srl  = 3'b101;  // SRL and SRA
    localparam logic [2:0] F3Or   = 3'b110;
    localparam logic [2:0] F3And  = 3'b111;

    // funct3 codes for branch conditions
    localparam logic [2:0] F3Beq  = 3'b000;
    localparam logic [2:0] F3Bne  = 3'b001;
    localparam logic [2:0] F3Blt  = 3'b100;
    localparam logic [2:0] F3Bge  = 3'b101;
    localparam logic [2:0] F3Bltu = 3'b110;
    localparam logic [2:0] F3Bgeu = 3'b111;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluSll, AluSlt, AluSltu, AluXor,
        AluSrl, AluSra, AluOr, AluAnd, AluPassB
    } AluOp;

    typedef enum logic [1:0] {OpASelRegA, OpASelPc, OpASelZero} OperandASel;
    typedef enum logic [1:0] {OpBSelRegB, OpBSelImm, OpBSelFour} OperandBSel;
    typedef enum logic [1:0] {RegWrSelAlu, RegWrSelLoad, RegWrSelPc4} RegWrSel;
    typedef enum logic [1:0] {PcSelPlus4, PcSelOffset, PcSelRs1} PcNextSel;

    // Full control word of one instruction, 14 bits
    typedef struct packed {
        AluOp       aluOp;
        OperandASel operandASel;
        OperandBSel operandBSel;
        RegWrSel    regWrSel;
        PcNextSel   pcNextSel;
        logic       regWrEnable;
        logic       memWrEnable;
    } DpControl;

    // Core to data memory request, 65 bits
    typedef struct packed {
        DataAddr addr;
        logic    we;
        Data     wdata;
    } DataBusReq;

endpackage

/* hdl/CoreSC.sv */
//--------------------------------------------------------------------
// CoreSC
// Single-cycle RV32I core top level. Holds the PC, the PC adders
// and the datapath selectors, and drives the instruction address
// and the data memory request. One instruction per clock.
//--------------------------------------------------------------------

`timescale 1ns/1ps

module CoreSC (
    input  logic               i_clock,      // Clock
    input  logic               i_rst,        // Synchronous reset
    input  CorePkg::Inst       i_inst,       // Fetched instruction
    input  CorePkg::Data       i_dataRdata,  // Load data
    output CorePkg::InstAddr   o_instAddr,   // Fetch address
    output CorePkg::DataBusReq o_dataReq);   // Data memory request

    CorePkg::InstAddr  pc;
    CorePkg::InstAddr  pcNext;
    CorePkg::InstAddr  pcPlus4;
    CorePkg::InstAddr  pcPlusOffset;
    CorePkg::InstAddr  pcPlusRs1;     // JALR target
    CorePkg::GPRAddr   decRs1;
    CorePkg::GPRAddr   decRs2;
    CorePkg::GPRAddr   decRd;
    CorePkg::Data      decImm;
    CorePkg::DpControl ctrl;
    CorePkg::Data      gprRdataA;
    CorePkg::Data      gprRdataB;
    CorePkg::Data      operandA;
    CorePkg::Data      operandB;
    CorePkg::Data      aluResult;
    CorePkg::Data      regWrData;

    //--------------------------------------------------------------------
    // Decode and control
    //--------------------------------------------------------------------

    InstDecoder dec (
        .i_inst (i_inst),
        .o_rs1  (decRs1),
        .o_rs2  (decRs2),
        .o_rd   (decRd),
        .o_imm  (decImm));

    DatapathController dpCtrl (
        .i_inst    (i_inst),
        .i_dataRs1 (gprRdataA),
        .i_dataRs2 (gprRdataB),
        .o_ctrl    (ctrl));

    GPRegisters gpr (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_raddrA (decRs1),
        .i_raddrB (decRs2),
        .i_waddr  (decRd),
        .i_we     (ctrl.regWrEnable),
        .i_wdata  (regWrData),
        .o_rdataA (gprRdataA),
        .o_rdataB (gprRdataB));

    //--------------------------------------------------------------------
    // Execute
    //--------------------------------------------------------------------

    always_comb begin
        case (ctrl.operandASel)
            CorePkg::OpASelRegA: operandA = gprRdataA;
            CorePkg::OpASelPc:   operandA = pc;
            default:             operandA = '0;  // Zero
        endcase
        case (ctrl.operandBSel)
            CorePkg::OpBSelRegB: operandB = gprRdataB;
            CorePkg::OpBSelImm:  operandB = decImm;
            default:             operandB = 32'd4;  // Four
        endcase
    end

    ALU alu (
        .i_op     (ctrl.aluOp),
        .i_dataA  (operandA),
        .i_dataB  (operandB),
        .o_result (aluResult));

    // Write-back selector
    always_comb begin
        case (ctrl.regWrSel)
            CorePkg::RegWrSelAlu:  regWrData = aluResult;
            CorePkg::RegWrSelLoad: regWrData = i_dataRdata;
            default:               regWrData = pcPlus4;  // Link
        endcase
    end

    //--------------------------------------------------------------------
    // Program counter
    //--------------------------------------------------------------------

    assign pcPlus4      = pc + 32'd4;
    assign pcPlusOffset = pc + decImm;
    assign pcPlusRs1    = (gprRdataA + decImm) & ~32'd1;  // Bit 0 cleared

    always_comb begin
        case (ctrl.pcNextSel)
            CorePkg::PcSelOffset: pcNext = pcPlusOffset;  // Branch, JAL
            CorePkg::PcSelRs1:    pcNext = pcPlusRs1;     // JALR
            default:              pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_rst)
            pc <= CorePkg::ResetPc;
        else
            pc <= pcNext;
    end

    // Bus outputs
    assign o_instAddr      = pc;
    assign o_dataReq.addr  = aluResult;                      // rs1 + offset
    assign o_dataReq.we    = ctrl.memWrEnable && !i_rst;     // No stores in reset
    assign o_dataReq.wdata = gprRdataB;

endmodule

/* hdl/DatapathController.sv */
//--------------------------------------------------------------------
// DatapathController
// Decodes opcode, funct3 and funct7 into the datapath control word
// and resolves conditional branches from the register values.
//--------------------------------------------------------------------

`timescale 1ns/1ps

module DatapathController (
    input  CorePkg::Inst      i_inst,     // Instruction word
    input  CorePkg::Data      i_dataRs1,  // Value of rs1
    input  CorePkg::Data      i_dataRs2,  // Value of rs2
    output CorePkg::DpControl o_ctrl);    // Control word

    CorePkg::Opcode opcode;
    logic [2:0]     funct3;
    logic           funct7Bit5;     // SUB and SRA marker
    logic           isEqual;
    logic           isLessSigned;
    logic           isLessUnsigned;
    logic           branchTaken;

    assign opcode     = CorePkg::Opcode'(i_inst[6:0]);
    assign funct3     = i_inst[14:12];
    assign funct7Bit5 = i_inst[30];

    // ALU operation from funct3, SUB only for register form
    function automatic CorePkg::AluOp decodeAluOp(input logic [2:0] f3,
                                                  input logic       alt,
                                                  input logic       isReg);
        CorePkg::AluOp op;
        case (f3)
            CorePkg::F3Add:  op = (isReg && alt) ? CorePkg::AluSub : CorePkg::AluAdd;
            CorePkg::F3Sll:  op = CorePkg::AluSll;
            CorePkg::F3Slt:  op = CorePkg::AluSlt;
            CorePkg::F3Sltu: op = CorePkg::AluSltu;
            CorePkg::F3Xor:  op = CorePkg::AluXor;
            CorePkg::F3Srl:  op = alt ? CorePkg::AluSra : CorePkg::AluSrl;
            CorePkg::F3Or:   op = CorePkg::AluOr;
            CorePkg::F3And:  op = CorePkg::AluAnd;
            default:         op = CorePkg::AluAdd;
        endcase
        return op;
    endfunction

    //--------------------------------------------------------------------
    // Branch comparison
    //--------------------------------------------------------------------

    assign isEqual        = i_dataRs1 == i_dataRs2;
    assign isLessSigned   = $signed(i_dataRs1) < $signed(i_dataRs2);
    assign isLessUnsigned = i_dataRs1 < i_dataRs2;

    always_comb begin
        case (funct3)
            CorePkg::F3Beq:  branchTaken = isEqual;
            CorePkg::F3Bne:  branchTaken = !isEqual;
            CorePkg::F3Blt:  branchTaken = isLessSigned;
            CorePkg::F3Bge:  branchTaken = !isLessSigned;
            CorePkg::F3Bltu: branchTaken = isLessUnsigned;
            CorePkg::F3Bgeu: branchTaken = !isLessUnsigned;
            default:         branchTaken = 1'b0;  // Reserved codes never jump
        endcase
    end

    //--------------------------------------------------------------------
    // Control word
    //--------------------------------------------------------------------

    always_comb begin
        // No-op defaults, also used for unknown opcodes
        o_ctrl.aluOp       = CorePkg::AluAdd;
        o_ctrl.operandASel = CorePkg::OpASelRegA;
        o_ctrl.operandBSel = CorePkg::OpBSelRegB;
        o_ctrl.regWrSel    = CorePkg::RegWrSelAlu;
        o_ctrl.pcNextSel   = CorePkg::PcSelPlus4;
        o_ctrl.regWrEnable = 1'b0;
        o_ctrl.memWrEnable = 1'b0;

        case (opcode)
            CorePkg::OpcLui: begin
                o_ctrl.aluOp       = CorePkg::AluPassB;
                o_ctrl.operandASel = CorePkg::OpASelZero;
                o_ctrl.operandBSel = CorePkg::OpBSelImm;
                o_ctrl.regWrEnable = 1'b1;
            end
            CorePkg::OpcAuipc: begin
                o_ctrl.operandASel = CorePkg::OpASelPc;   // PC + upper imm
                o_ctrl.operandBSel = CorePkg::OpBSelImm;
                o_ctrl.regWrEnable = 1'b1;
            end
            CorePkg::OpcJal, CorePkg::OpcJalr: begin
                o_ctrl.operandASel = CorePkg::OpASelPc;   // ALU mirrors PC+4
                o_ctrl.operandBSel = CorePkg::OpBSelFour;
                o_ctrl.regWrSel    = CorePkg::RegWrSelPc4;  // Link value
                o_ctrl.pcNextSel   = (opcode == CorePkg::OpcJal) ?
                                     CorePkg::PcSelOffset : CorePkg::PcSelRs1;
                o_ctrl.regWrEnable = 1'b1;
            end
            CorePkg::OpcBranch: begin
                o_ctrl.aluOp     = CorePkg::AluSub;
                o_ctrl.pcNextSel = branchTaken ? CorePkg::PcSelOffset : CorePkg::PcSelPlus4;
            end
            CorePkg::OpcLoad: begin
                o_ctrl.operandBSel = CorePkg::OpBSelImm;  // rs1 + offset
                o_ctrl.regWrSel    = CorePkg::RegWrSelLoad;
                o_ctrl.regWrEnable = 1'b1;
            end
            CorePkg::OpcStore: begin
                o_ctrl.operandBSel = CorePkg::OpBSelImm;
                o_ctrl.memWrEnable = 1'b1;
            end
            CorePkg::OpcOpImm: begin
                o_ctrl.aluOp       = decodeAluOp(funct3, funct7Bit5, 1'b0);
                o_ctrl.operandBSel = CorePkg::OpBSelImm;
                o_ctrl.regWrEnable = 1'b1;
            end
            CorePkg::OpcOp: begin
                o_ctrl.aluOp       = decodeAluOp(funct3, funct7Bit5, 1'b1);
                o_ctrl.regWrEnable = 1'b1;
            end
            default: ;  // Keep the no-op word
        endcase
    end

endmodule

/* hdl/GPRegisters.sv */
//--------------------------------------------------------------------
// GPRegisters
// 32x32 register file, two combinational reads and one write at
// the rising edge. x0 always reads zero.
//--------------------------------------------------------------------

`timescale 1ns/1ps

module GPRegisters (
    input  logic            i_clock,   // Clock
    input  logic            i_rst,     // Synchronous reset
    input  CorePkg::GPRAddr i_raddrA,  // Read address A
    input  CorePkg::GPRAddr i_raddrB,  // Read address B
    input  CorePkg::GPRAddr i_waddr,   // Write address
    input  logic            i_we,      // Write enable
    input  CorePkg::Data    i_wdata,   // Write data
    output CorePkg::Data    o_rdataA,  // Read data A
    output CorePkg::Data    o_rdataB); // Read data B

    CorePkg::Data regs [1:31];  // x1 to x31

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_we && (i_waddr != 5'd0))  // Writes to x0 dropped
            regs[i_waddr] <= i_wdata;
    end

    // No bypass, a write shows up in the next cycle
    assign o_rdataA = (i_raddrA == 5'd0) ? '0 : regs[i_raddrA];
    assign o_rdataB = (i_raddrB == 5'd0) ? '0 : regs[i_raddrB];

endmodule

/* hdl/InstDecoder.sv */
//--------------------------------------------------------------------
// InstDecoder
// Extracts the register fields of an RV32I instruction and builds
// the sign-extended immediate of its format (I, S, B, U or J).
//--------------------------------------------------------------------

`timescale 1ns/1ps

module InstDecoder (
    input  CorePkg::Inst    i_inst,  // Instruction word
    output CorePkg::GPRAddr o_rs1,   // Source register 1
    output CorePkg::GPRAddr o_rs2,   // Source register 2
    output CorePkg::GPRAddr o_rd,    // Destination register
    output CorePkg::Data    o_imm);  // Immediate, sign-extended

    CorePkg::Opcode opcode;
    CorePkg::Data   immI;
    CorePkg::Data   immS;
    CorePkg::Data   immB;
    CorePkg::Data   immU;
    CorePkg::Data   immJ;

    assign opcode = CorePkg::Opcode'(i_inst[6:0]);

    // Register fields sit at fixed positions in every format
    assign o_rs1 = i_inst[19:15];
    assign o_rs2 = i_inst[24:20];
    assign o_rd  = i_inst[11:7];

    //--------------------------------------------------------------------
    // Immediate formats
    //--------------------------------------------------------------------

    assign immI = {{20{i_inst[31]}}, i_inst[31:20]};
    assign immS = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign immB = {{19{i_inst[31]}}, i_inst[31], i_inst[7],   // Bit 12 and 11
                   i_inst[30:25], i_inst[11:8], 1'b0};        // Always even
    assign immU = {i_inst[31:12], 12'b0};                     // Upper 20 bits
    assign immJ = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                   i_inst[20], i_inst[30:21], 1'b0};

    // Format chosen by opcode
    always_comb begin
        case (opcode)
            CorePkg::OpcJalr,
            CorePkg::OpcLoad,
            CorePkg::OpcOpImm:  o_imm = immI;
            CorePkg::OpcStore:  o_imm = immS;
            CorePkg::OpcBranch: o_imm = immB;
            CorePkg::OpcLui,
            CorePkg::OpcAuipc:  o_imm = immU;
            CorePkg::OpcJal:    o_imm = immJ;
            default:            o_imm = '0;  // R format and unknown
        endcase
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the CoreSC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f CoreSC.f --top-module CoreSCTb -o CoreSCTb

output=$(./obj_dir/CoreSCTb 2>&1) || true
echo "$output"

echo "$output" | grep -q "Testbench passed"

/* tests/CoreSCTb.sv */
//--------------------------------------------------------------------
// CoreSCTb
// Testbench for the single-cycle RV32I core. Builds a random program,
// serves instruction and data memory, runs an ISA reference model in
// lock step and compares the PC, every store and the final memory.
//--------------------------------------------------------------------

`timescale 1ns/1ps

module CoreSCTb;

    localparam int ProgLen       = 400;          // Generated instructions
    localparam int ProgEnd       = ProgLen * 4;  // First byte past the program
    localparam int TimeoutCycles = 500 + 20;     // Instruction budget plus margin
    localparam logic [31:0] Nop  = 32'h0000_0013;  // ADDI x0, x0, 0

    logic              clk = 1'b0;
    logic              i_rst;
    CorePkg::Inst      i_inst;
    CorePkg::Data      i_dataRdata;
    CorePkg::InstAddr  o_instAddr;
    CorePkg::DataBusReq o_dataReq;

    logic [31:0] prog [0:511];      // Program indexed by PC/4
    logic [31:0] dataMem [0:63];    // Data memory seen by the DUT
    logic [31:0] modelMem [0:63];   // Reference model memory
    logic [31:0] modelRegs [0:31];  // Reference model registers
    logic [31:0] modelPc;
    logic [31:0] rngState = 32'hc2b5_0d5c;
    int          cycles = 0;

    CoreSC UUT (
        .i_clock     (clk),
        .i_rst       (i_rst),
        .i_inst      (i_inst),
        .i_dataRdata (i_dataRdata),
        .o_instAddr  (o_instAddr),
        .o_dataReq   (o_dataReq));

    initial begin
        forever #50 clk = ~clk;  // 100 ns period
    end

    // Combinational memories with writes at the rising edge
    assign i_inst      = prog[o_instAddr[10:2]];
    assign i_dataRdata = dataMem[o_dataReq.addr[7:2]];

    always @(posedge clk) begin
        if (o_dataReq.we)
            dataMem[o_dataReq.addr[7:2]] <= o_dataReq.wdata;
    end

    // Run limit counted after reset
    always @(posedge clk) begin
        if (!i_rst)
            cycles <= cycles + 1;
        if (cycles >= TimeoutCycles) begin
            $display("Timeout: the program did not finish within %0d cycles", TimeoutCycles);
            $display("Testbench failed");
            $fatal(1, "Run limit reached");
        end
    end

    function automatic logic [31:0] xorshift();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: actual 0x%08h expected 0x%08h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    //--------------------------------------------------------------------
    // Random program
    //--------------------------------------------------------------------

    task automatic genProgram();
        logic [31:0] r;
        logic [31:0] off;
        logic [11:0] imm12;
        logic [2:0]  f3;
        logic [4:0]  rs2;
        for (int i = 0; i < 512; i++)
            prog[i] = Nop;  // Padding past the end
        for (int i = 0; i < ProgLen; i++) begin
            r     = xorshift();
            off   = 32'd8 + 32'd4 * (r[31:28] % 32'd7);  // Forward 8 to 32 bytes
            imm12 = {4'b0, r[25:20], 2'b00};             // Word offset 0 to 252
            f3    = r[14:12];
            if (i % 4 == 0)  // SW of a random register, also the one fetched in reset
                prog[i] = {imm12[11:5], r[4:0], 5'd0, 3'b010, imm12[4:0], 7'b0100011};
            else begin
                case (r[6:4])
                    3'd0: prog[i] = {1'b0, r[30] & (f3 == 3'd0 || f3 == 3'd5), 5'b0,
                                     r[24:7], 7'b0110011};  // Register ALU op
                    3'd1, 3'd2: begin
                        imm12 = r[31:20];
                        if (f3 == 3'd1)
                            imm12[11:5] = 7'd0;             // SLLI
                        else if (f3 == 3'd5)
                            imm12[11:5] = {1'b0, r[30], 5'd0};  // SRLI or SRAI
                        prog[i] = {imm12, r[19:7], 7'b0010011};
                    end
                    3'd3: prog[i] = {r[31:7], r[3] ? 7'b0110111 : 7'b0010111};
                    3'd4: prog[i] = {imm12, 5'd0, 3'b010, r[11:7], 7'b0000011};  // LW
                    3'd5: begin
                        if (r[14:13] == 2'b01)
                            f3 = {2'b11, r[12]};  // Skip reserved codes
                        rs2 = r[3] ? r[19:15] : r[24:20];  // Sometimes rs1 == rs2
                        prog[i] = {off[12], off[10:5], rs2, r[19:15], f3,
                                   off[4:1], off[11], 7'b1100011};
                    end
                    3'd6: prog[i] = {off[20], off[10:1], off[11], off[19:12],
                                     r[11:7], 7'b1101111};  // JAL
                    default: begin
                        imm12 = 12'(i * 4 + off);  // Absolute target with rs1 = x0
                        prog[i] = {imm12, 5'd0, 3'b000, r[11:7], 7'b1100111};
                    end
                endcase
            end
        end
    endtask

    //--------------------------------------------------------------------
    // Reference model
    //--------------------------------------------------------------------

    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Steps one instruction and checks the store request of this cycle
    task automatic stepModel();
        logic [31:0] in;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] res;
        logic [31:0] ea;
        logic [31:0] nextPc;
        logic [2:0]  f3;
        logic        wr;
        logic        taken;
        in     = prog[modelPc[10:2]];
        a      = modelRegs[in[19:15]];
        b      = modelRegs[in[24:20]];
        f3     = in[14:12];
        immI   = {{20{in[31]}}, in[31:20]};
        immS   = {{20{in[31]}}, in[31:25], in[11:7]};
        immB   = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
        immJ   = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
        nextPc = modelPc + 32'd4;
        res    = 32'd0;
        wr     = 1'b1;
        case (in[6:0])
            7'b0110111: res = {in[31:12], 12'b0};             // LUI
            7'b0010111: res = modelPc + {in[31:12], 12'b0};   // AUIPC
            7'b1101111: begin
                res    = modelPc + 32'd4;
                nextPc = modelPc + immJ;
            end
            7'b1100111: begin
                res    = modelPc + 32'd4;
                nextPc = (a + immI) & ~32'd1;
            end
            7'b1100011: begin
                wr = 1'b0;
                case (f3)
                    3'b000:  taken = a == b;
                    3'b001:  taken = a != b;
                    3'b100:  taken = $signed(a) < $signed(b);
                    3'b101:  taken = $signed(a) >= $signed(b);
                    3'b110:  taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken)
                    nextPc = modelPc + immB;
            end
            7'b0000011: begin
                ea  = a + immI;
                res = modelMem[ea[7:2]];
            end
            7'b0100011: begin
                wr = 1'b0;
                ea = a + immS;
                check("o_dataReq.we", {31'b0, o_dataReq.we}, 32'd1);
                check("o_dataReq.addr", o_dataReq.addr, ea);
                check("o_dataReq.wdata", o_dataReq.wdata, b);
                modelMem[ea[7:2]] = b;
            end
            7'b0010011: res = refAlu(f3, in[30] && f3 == 3'd5, a, immI);
            7'b0110011: res = refAlu(f3, in[30], a, b);
            default:    wr = 1'b0;  // Unknown acts as no-op
        endcase
        if (in[6:0] != 7'b0100011)
            check("o_dataReq.we", {31'b0, o_dataReq.we}, 32'd0);
        if (wr && in[11:7] != 5'd0)
            modelRegs[in[11:7]] = res;  // x0 never written
        modelPc = nextPc;
    endtask

    //--------------------------------------------------------------------
    // Main sequence
    //--------------------------------------------------------------------

    initial begin
        i_rst = 1'b1;
        genProgram();
        for (int i = 0; i < 64; i++) begin
            dataMem[i]  = 32'hd00d_0000 ^ (i * 32'h0001_0103);  // Address dependent fill
            modelMem[i] = 32'hd00d_0000 ^ (i * 32'h0001_0103);
        end
        for (int i = 0; i < 32; i++)
            modelRegs[i] = 32'd0;
        modelPc = CorePkg::ResetPc;

        repeat (5) begin
            @(negedge clk);
            check("o_dataReq.we", {31'b0, o_dataReq.we}, 32'd0);  // Quiet in reset
        end
        i_rst = 1'b0;
        #1;
        check("o_instAddr", o_instAddr, CorePkg::ResetPc);

        while (modelPc < ProgEnd) begin
            check("o_instAddr", o_instAddr, modelPc);
            stepModel();
            @(negedge clk);  // DUT retired the instruction
        end

        for (int i = 0; i < 64; i++)
            check($sformatf("dataMem[%0d]", i), dataMem[i], modelMem[i]);
        $display("Testbench passed");
        $finish;
    end

endmodule

/* tests/CoreSC_checker.sv */
//--------------------------------------------------------------------
// CoreSCChecker
// Assertions on the bus outputs of the core, bound into CoreSC.
//--------------------------------------------------------------------

`timescale 1ns/1ps

module CoreSCChecker (
    input logic               i_clock,
    input logic               i_rst,
    input CorePkg::InstAddr   i_instAddr,  // Fetch address of the core
    input CorePkg::DataBusReq i_dataReq);  // Data request of the core

    // No store strobe while in reset
    weLowInReset: assert property (@(posedge i_clock) i_rst |-> !i_dataReq.we)
        else $error("Data write strobe high during reset");

    // Fetch always on a word boundary
    instAligned: assert property (@(posedge i_clock) !i_rst |-> i_instAddr[1:0] == 2'b00)
        else $error("Fetch address not word aligned");

    // First fetch after reset
    resetPcAfterReset: assert property (@(posedge i_clock)
        $fell(i_rst) |-> i_instAddr == CorePkg::ResetPc)
        else $error("Fetch address wrong after reset");

endmodule

bind CoreSC CoreSCChecker busChecks (
    .i_clock    (i_clock),
    .i_rst      (i_rst),
    .i_instAddr (o_instAddr),
    .i_dataReq  (o_dataReq));
